//--- source/axil_pkg.sv
// **************************************************
// AXI4-Lite types
// Channel widths, request and response bundles and
// response codes shared by the crossbar
// **************************************************
package axil_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;  // One strobe per byte

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [1:0]            resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // Manager to subordinate
  typedef struct packed {
    addr_t aw_addr;
    logic  aw_valid;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } axil_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    resp_t b_resp;
    logic  b_valid;
    logic  ar_ready;
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
  } axil_resp_t;

endpackage

//--- source/xbar_pkg.sv
// **************************************************
// Crossbar configuration types
// Address rule layout for the decoders
// **************************************************
package xbar_pkg;

  localparam int unsigned IDX_WIDTH = 8;  // Room for up to 256 master ports

  // Maps [start_addr, end_addr) onto master port idx
  typedef struct packed {
    logic [IDX_WIDTH-1:0]            idx;
    logic [axil_pkg::ADDR_WIDTH-1:0] start_addr;
    logic [axil_pkg::ADDR_WIDTH-1:0] end_addr;   // Exclusive
  } rule_t;

endpackage

//--- source/addr_decode.sv
// **************************************************
// Address decoder
// Matches an address against the rule table, falls
// back to a default index or flags a decode error
// **************************************************
`timescale 1ns/1ps

module addr_decode #(
  parameter int unsigned NumIdx   = 2,
  parameter int unsigned NumRules = 2,
  localparam int unsigned IdxWidth = (NumIdx > 1) ? $clog2(NumIdx) : 1
) (
  input  axil_pkg::addr_t                 addr_i,
  input  xbar_pkg::rule_t [NumRules-1:0]  addr_map_i,
  input  logic                            en_default_i,
  input  logic [IdxWidth-1:0]             default_idx_i,
  output logic [IdxWidth-1:0]             idx_o,
  output logic                            dec_error_o
);

  always_comb begin
    // Unmapped until a rule hits
    idx_o       = en_default_i ? default_idx_i : '0;
    dec_error_o = ~en_default_i;

    // Later rules override earlier ones
    for (int unsigned r = 0; r < NumRules; r++) begin
      if (addr_i >= addr_map_i[r].start_addr && addr_i < addr_map_i[r].end_addr) begin
        idx_o       = addr_map_i[r].idx[IdxWidth-1:0];
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

//--- source/axil_demux.sv
// **************************************************
// AXI4-Lite demultiplexer
// Steers one slave port to a selected target, one
// write and one read outstanding at a time
// **************************************************
`timescale 1ns/1ps

module axil_demux #(
  parameter int unsigned NumMstPorts = 3,  // Includes the error port
  localparam int unsigned SelWidth = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  axil_pkg::axil_req_t                    slv_req_i,
  output axil_pkg::axil_resp_t                   slv_resp_o,
  input  logic [SelWidth-1:0]                    aw_select_i,
  input  logic [SelWidth-1:0]                    ar_select_i,
  output axil_pkg::axil_req_t  [NumMstPorts-1:0] mst_req_o,
  input  axil_pkg::axil_resp_t [NumMstPorts-1:0] mst_resp_i
);

  logic                w_pend_q, w_done_q, r_pend_q;
  logic [SelWidth-1:0] w_sel_q, r_sel_q;  // Target of the open write and read
  logic                aw_hs, w_hs, b_hs, ar_hs, r_hs;

  // Requests fan out, only the selected target sees valid or ready
  always_comb begin
    for (int unsigned i = 0; i < NumMstPorts; i++) begin
      mst_req_o[i]          = slv_req_i;
      mst_req_o[i].aw_valid = 1'b0;
      mst_req_o[i].w_valid  = 1'b0;
      mst_req_o[i].b_ready  = 1'b0;
      mst_req_o[i].ar_valid = 1'b0;
      mst_req_o[i].r_ready  = 1'b0;
    end
    if (!w_pend_q) begin
      mst_req_o[aw_select_i].aw_valid = slv_req_i.aw_valid;
    end else begin
      mst_req_o[w_sel_q].w_valid = slv_req_i.w_valid & ~w_done_q;  // Single W beat
      mst_req_o[w_sel_q].b_ready = slv_req_i.b_ready;
    end
    if (!r_pend_q) begin
      mst_req_o[ar_select_i].ar_valid = slv_req_i.ar_valid;
    end else begin
      mst_req_o[r_sel_q].r_ready = slv_req_i.r_ready;
    end
  end

  // Responses come back from the recorded target
  always_comb begin
    slv_resp_o = '0;
    if (!w_pend_q) begin
      slv_resp_o.aw_ready = mst_resp_i[aw_select_i].aw_ready;
    end else begin
      slv_resp_o.w_ready = mst_resp_i[w_sel_q].w_ready & ~w_done_q;
      slv_resp_o.b_valid = mst_resp_i[w_sel_q].b_valid;
      slv_resp_o.b_resp  = mst_resp_i[w_sel_q].b_resp;
    end
    if (!r_pend_q) begin
      slv_resp_o.ar_ready = mst_resp_i[ar_select_i].ar_ready;
    end else begin
      slv_resp_o.r_valid = mst_resp_i[r_sel_q].r_valid;
      slv_resp_o.r_data  = mst_resp_i[r_sel_q].r_data;
      slv_resp_o.r_resp  = mst_resp_i[r_sel_q].r_resp;
    end
  end

  assign aw_hs = slv_req_i.aw_valid & slv_resp_o.aw_ready;
  assign w_hs  = slv_req_i.w_valid  & slv_resp_o.w_ready;
  assign b_hs  = slv_resp_o.b_valid & slv_req_i.b_ready;
  assign ar_hs = slv_req_i.ar_valid & slv_resp_o.ar_ready;
  assign r_hs  = slv_resp_o.r_valid & slv_req_i.r_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_pend_q <= 1'b0;
      w_done_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        w_pend_q <= 1'b1;
        w_done_q <= 1'b0;
      end else if (b_hs) begin
        w_pend_q <= 1'b0;
      end
      if (w_hs) w_done_q <= 1'b1;
      if (ar_hs) r_pend_q <= 1'b1;
      else if (r_hs) r_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) w_sel_q <= aw_select_i;
    if (ar_hs) r_sel_q <= ar_select_i;
  end

  // Manager must not move an address that is waiting
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_req_i.aw_valid && !slv_resp_o.aw_ready) |=> $stable(slv_req_i.aw_addr))
    else $error("aw_addr changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_req_i.ar_valid && !slv_resp_o.ar_ready) |=> $stable(slv_req_i.ar_addr))
    else $error("ar_addr changed while stalled");

endmodule

//--- source/axil_mux.sv
// **************************************************
// AXI4-Lite multiplexer
// Round-robin arbitration of one master port among
// the slave ports, separately for writes and reads
// **************************************************
`timescale 1ns/1ps

module axil_mux #(
  parameter int unsigned NumSlvPorts = 2,
  localparam int unsigned IdxWidth = (NumSlvPorts > 1) ? $clog2(NumSlvPorts) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  axil_pkg::axil_req_t  [NumSlvPorts-1:0] slv_req_i,
  output axil_pkg::axil_resp_t [NumSlvPorts-1:0] slv_resp_o,
  output axil_pkg::axil_req_t                    mst_req_o,
  input  axil_pkg::axil_resp_t                   mst_resp_i
);

  logic                w_busy_q, r_busy_q;      // Channel owned until B / R
  logic [IdxWidth-1:0] w_owner_q, r_owner_q;
  logic [IdxWidth-1:0] w_rr_q, r_rr_q;          // Highest priority next round
  logic [IdxWidth-1:0] aw_gnt, ar_gnt;
  logic                aw_gnt_valid, ar_gnt_valid;
  logic                aw_hs, b_hs, ar_hs, r_hs;

  // Walk downwards so the requester closest to the pointer wins
  always_comb begin
    int unsigned cand;
    aw_gnt       = '0;
    aw_gnt_valid = 1'b0;
    ar_gnt       = '0;
    ar_gnt_valid = 1'b0;
    for (int k = NumSlvPorts - 1; k >= 0; k--) begin
      cand = (int'(w_rr_q) + k) % NumSlvPorts;
      if (slv_req_i[cand].aw_valid) begin
        aw_gnt       = IdxWidth'(cand);
        aw_gnt_valid = 1'b1;
      end
      cand = (int'(r_rr_q) + k) % NumSlvPorts;
      if (slv_req_i[cand].ar_valid) begin
        ar_gnt       = IdxWidth'(cand);
        ar_gnt_valid = 1'b1;
      end
    end
  end

  always_comb begin
    mst_req_o = '0;
    if (!w_busy_q) begin
      mst_req_o.aw_addr  = slv_req_i[aw_gnt].aw_addr;
      mst_req_o.aw_valid = aw_gnt_valid;
    end else begin
      mst_req_o.w_data  = slv_req_i[w_owner_q].w_data;
      mst_req_o.w_strb  = slv_req_i[w_owner_q].w_strb;
      mst_req_o.w_valid = slv_req_i[w_owner_q].w_valid;
      mst_req_o.b_ready = slv_req_i[w_owner_q].b_ready;
    end
    if (!r_busy_q) begin
      mst_req_o.ar_addr  = slv_req_i[ar_gnt].ar_addr;
      mst_req_o.ar_valid = ar_gnt_valid;
    end else begin
      mst_req_o.r_ready = slv_req_i[r_owner_q].r_ready;
    end
  end

  always_comb begin
    slv_resp_o = '0;
    if (!w_busy_q) begin
      slv_resp_o[aw_gnt].aw_ready = mst_resp_i.aw_ready & aw_gnt_valid;
    end else begin
      slv_resp_o[w_owner_q].w_ready = mst_resp_i.w_ready;
      slv_resp_o[w_owner_q].b_valid = mst_resp_i.b_valid;
      slv_resp_o[w_owner_q].b_resp  = mst_resp_i.b_resp;
    end
    if (!r_busy_q) begin
      slv_resp_o[ar_gnt].ar_ready = mst_resp_i.ar_ready & ar_gnt_valid;
    end else begin
      slv_resp_o[r_owner_q].r_valid = mst_resp_i.r_valid;
      slv_resp_o[r_owner_q].r_data  = mst_resp_i.r_data;
      slv_resp_o[r_owner_q].r_resp  = mst_resp_i.r_resp;
    end
  end

  assign aw_hs = mst_req_o.aw_valid & mst_resp_i.aw_ready;
  assign b_hs  = mst_resp_i.b_valid & mst_req_o.b_ready;
  assign ar_hs = mst_req_o.ar_valid & mst_resp_i.ar_ready;
  assign r_hs  = mst_resp_i.r_valid & mst_req_o.r_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_busy_q <= 1'b0;
      r_busy_q <= 1'b0;
      w_rr_q   <= '0;
      r_rr_q   <= '0;
    end else begin
      if (aw_hs) begin
        w_busy_q <= 1'b1;
        w_rr_q   <= (aw_gnt == IdxWidth'(NumSlvPorts - 1)) ? '0 : aw_gnt + 1'b1;
      end else if (b_hs) begin
        w_busy_q <= 1'b0;
      end
      if (ar_hs) begin
        r_busy_q <= 1'b1;
        r_rr_q   <= (ar_gnt == IdxWidth'(NumSlvPorts - 1)) ? '0 : ar_gnt + 1'b1;
      end else if (r_hs) begin
        r_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) w_owner_q <= aw_gnt;
    if (ar_hs) r_owner_q <= ar_gnt;
  end

  // Subordinate answers only a channel that has an owner
  assert property (@(posedge clk_i) disable iff (!rst_n_i) mst_resp_i.b_valid |-> w_busy_q)
    else $error("b_valid without an open write");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) mst_resp_i.r_valid |-> r_busy_q)
    else $error("r_valid without an open read");

endmodule

//--- source/axil_err_slv.sv
// **************************************************
// Decode error responder
// Accepts any write or read and answers DECERR
// **************************************************
`timescale 1ns/1ps

module axil_err_slv (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  axil_pkg::axil_req_t  req_i,
  output axil_pkg::axil_resp_t resp_o
);

  logic aw_got_q, w_got_q, b_valid_q, r_valid_q;
  logic aw_done, w_done;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = ~aw_got_q & ~b_valid_q;
    resp_o.w_ready  = ~w_got_q & ~b_valid_q;
    resp_o.b_valid  = b_valid_q;
    resp_o.b_resp   = axil_pkg::RESP_DECERR;
    resp_o.ar_ready = ~r_valid_q;
    resp_o.r_valid  = r_valid_q;
    resp_o.r_resp   = axil_pkg::RESP_DECERR;  // r_data stays zero
  end

  // AW and W may land in either order
  assign aw_done = aw_got_q | (req_i.aw_valid & resp_o.aw_ready);
  assign w_done  = w_got_q | (req_i.w_valid & resp_o.w_ready);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (aw_done && w_done) begin
        b_valid_q <= 1'b1;
        aw_got_q  <= 1'b0;
        w_got_q   <= 1'b0;
      end else begin
        aw_got_q <= aw_done;
        w_got_q  <= w_done;
        if (b_valid_q && req_i.b_ready) b_valid_q <= 1'b0;
      end
      if (req_i.ar_valid && resp_o.ar_ready) r_valid_q <= 1'b1;
      else if (r_valid_q && req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  // Next write address only once the pending B has gone
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.aw_valid |-> !resp_o.b_valid)
    else $error("new write address while B is pending");

endmodule

//--- source/axil_xbar.sv
// **************************************************
// AXI4-Lite crossbar
// Decoders and demuxes per slave port, round-robin
// muxes per master port, DECERR for unmapped space
// **************************************************
`timescale 1ns/1ps

module axil_xbar #(
  parameter int unsigned NumSlvPorts = 2,
  parameter int unsigned NumMstPorts = 2,
  parameter int unsigned NumRules    = 2,
  localparam int unsigned MstIdxWidth = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1,
  localparam int unsigned SelWidth    = $clog2(NumMstPorts + 1)  // Extra slot for DECERR
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  axil_pkg::axil_req_t  [NumSlvPorts-1:0]   slv_req_i,
  output axil_pkg::axil_resp_t [NumSlvPorts-1:0]   slv_resp_o,
  output axil_pkg::axil_req_t  [NumMstPorts-1:0]   mst_req_o,
  input  axil_pkg::axil_resp_t [NumMstPorts-1:0]   mst_resp_i,
  input  xbar_pkg::rule_t      [NumRules-1:0]      addr_map_i,
  input  logic [NumSlvPorts-1:0]                   en_default_i,
  input  logic [NumSlvPorts-1:0][MstIdxWidth-1:0]  default_idx_i
);

  // Demux side, last entry is the error responder
  axil_pkg::axil_req_t  [NumSlvPorts-1:0][NumMstPorts:0] demux_req;
  axil_pkg::axil_resp_t [NumSlvPorts-1:0][NumMstPorts:0] demux_resp;
  // Mux side, indexed by master port first
  axil_pkg::axil_req_t  [NumMstPorts-1:0][NumSlvPorts-1:0] mux_req;
  axil_pkg::axil_resp_t [NumMstPorts-1:0][NumSlvPorts-1:0] mux_resp;

  for (genvar i = 0; i < NumSlvPorts; i++) begin : gen_slv_port
    logic [MstIdxWidth-1:0] dec_aw, dec_ar;
    logic                   dec_aw_err, dec_ar_err;
    logic [SelWidth-1:0]    aw_select, ar_select;

    addr_decode #(.NumIdx(NumMstPorts), .NumRules(NumRules)) i_aw_decode (
      .addr_i        (slv_req_i[i].aw_addr),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_i[i]),
      .default_idx_i (default_idx_i[i]),
      .idx_o         (dec_aw),
      .dec_error_o   (dec_aw_err)
    );

    addr_decode #(.NumIdx(NumMstPorts), .NumRules(NumRules)) i_ar_decode (
      .addr_i        (slv_req_i[i].ar_addr),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_i[i]),
      .default_idx_i (default_idx_i[i]),
      .idx_o         (dec_ar),
      .dec_error_o   (dec_ar_err)
    );

    assign aw_select = dec_aw_err ? SelWidth'(NumMstPorts) : SelWidth'(dec_aw);
    assign ar_select = dec_ar_err ? SelWidth'(NumMstPorts) : SelWidth'(dec_ar);

    axil_demux #(.NumMstPorts(NumMstPorts + 1)) i_demux (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .slv_req_i   (slv_req_i[i]),
      .slv_resp_o  (slv_resp_o[i]),
      .aw_select_i (aw_select),
      .ar_select_i (ar_select),
      .mst_req_o   (demux_req[i]),
      .mst_resp_i  (demux_resp[i])
    );

    axil_err_slv i_err_slv (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (demux_req[i][NumMstPorts]),
      .resp_o  (demux_resp[i][NumMstPorts])
    );

    for (genvar j = 0; j < NumMstPorts; j++) begin : gen_cross
      assign mux_req[j][i]    = demux_req[i][j];
      assign demux_resp[i][j] = mux_resp[j][i];
    end
  end

  for (genvar j = 0; j < NumMstPorts; j++) begin : gen_mst_port
    axil_mux #(.NumSlvPorts(NumSlvPorts)) i_mux (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .slv_req_i  (mux_req[j]),
      .slv_resp_o (mux_resp[j]),
      .mst_req_o  (mst_req_o[j]),
      .mst_resp_i (mst_resp_i[j])
    );
  end

endmodule

//--- bench/tb_mem_slave.sv
// **************************************************
// Memory subordinate model
// 16 words with byte strobes, answers OKAY one
// cycle after each transfer
// **************************************************
`timescale 1ns/1ps

module tb_mem_slave #(
  parameter logic [31:0] Fill = 32'h0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  axil_pkg::axil_req_t  req_i,
  output axil_pkg::axil_resp_t resp_o
);

  axil_pkg::data_t mem [16];
  axil_pkg::data_t r_data_q;
  logic [3:0]      w_idx_q;  // Word picked by the accepted AW
  logic            aw_got_q, b_valid_q, r_valid_q;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = ~aw_got_q & ~b_valid_q;
    resp_o.w_ready  = aw_got_q;
    resp_o.b_valid  = b_valid_q;
    resp_o.b_resp   = axil_pkg::RESP_OKAY;
    resp_o.ar_ready = ~r_valid_q;
    resp_o.r_valid  = r_valid_q;
    resp_o.r_data   = r_data_q;
    resp_o.r_resp   = axil_pkg::RESP_OKAY;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_got_q  <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
      w_idx_q   <= '0;
      r_data_q  <= '0;
      for (int k = 0; k < 16; k++) begin
        mem[k] <= Fill + 32'(k) * 32'h0101_0101;  // Distinct word per index
      end
    end else begin
      if (req_i.aw_valid && resp_o.aw_ready) begin
        aw_got_q <= 1'b1;
        w_idx_q  <= req_i.aw_addr[5:2];
      end
      if (req_i.w_valid && resp_o.w_ready) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.w_strb[b]) mem[w_idx_q][8*b +: 8] <= req_i.w_data[8*b +: 8];
        end
        aw_got_q  <= 1'b0;
        b_valid_q <= 1'b1;
      end else if (b_valid_q && req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (req_i.ar_valid && resp_o.ar_ready) begin
        r_valid_q <= 1'b1;
        r_data_q  <= mem[req_i.ar_addr[5:2]];
      end else if (r_valid_q && req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

endmodule

//--- bench/tb_axil_xbar.sv
// **************************************************
// Crossbar testbench
// Two managers, two memory models, reference model
// of the address map and a cycle limit
// **************************************************
`timescale 1ns/1ps

module tb_axil_xbar;

  localparam int NUM_RAND   = 160;  // Per slave port in the concurrent phase
  localparam int NUM_TXN    = 400;
  localparam int MAX_CYCLES = NUM_TXN * 20 + 16 + 100;
  localparam int TXN_LAT    = 8;    // Worst case behind one competing port is 6
  localparam logic [31:0] FILL0 = 32'hA5A5_0000;
  localparam logic [31:0] FILL1 = 32'h5A5A_0000;

  logic clk_i;
  logic rst_n_i;
  axil_pkg::axil_req_t               mgr_req [2];
  axil_pkg::axil_req_t  [1:0]        slv_req;
  axil_pkg::axil_resp_t [1:0]        slv_resp;
  axil_pkg::axil_req_t  [1:0]        mst_req;
  axil_pkg::axil_resp_t [1:0]        mst_resp;
  xbar_pkg::rule_t      [1:0]        addr_map;
  logic                 [1:0]        en_default;
  logic                 [1:0][0:0]   default_idx;

  axil_pkg::data_t model [2][16];
  logic [31:0]     lcg_state;
  int              n_checks;
  int              n_errors;
  int              cycles = 0;

  assign slv_req[0] = mgr_req[0];
  assign slv_req[1] = mgr_req[1];

  axil_xbar #(.NumSlvPorts(2), .NumMstPorts(2), .NumRules(2)) i_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .slv_req_i     (slv_req),
    .slv_resp_o    (slv_resp),
    .mst_req_o     (mst_req),
    .mst_resp_i    (mst_resp),
    .addr_map_i    (addr_map),
    .en_default_i  (en_default),
    .default_idx_i (default_idx)
  );

  tb_mem_slave #(.Fill(FILL0)) i_mem0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mst_req[0]),
    .resp_o  (mst_resp[0])
  );
  tb_mem_slave #(.Fill(FILL1)) i_mem1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mst_req[1]),
    .resp_o  (mst_resp[1])
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: transactions still open after %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Region 0 and 1 are mapped, region 2 lies outside every rule
  function automatic axil_pkg::addr_t make_addr(int region, int word);
    return 32'(region) * 32'h1000 + 32'(word) * 32'd4;
  endfunction

  // Target master port, -1 for the error responder
  function automatic int route(int p, axil_pkg::addr_t a);
    if (a < 32'h1000) return 0;
    if (a < 32'h2000) return 1;
    if (en_default[p]) return int'(default_idx[p]);
    return -1;
  endfunction

  function automatic axil_pkg::resp_t ref_write(int p, axil_pkg::addr_t a,
                                                axil_pkg::data_t d, axil_pkg::strb_t s);
    int t;
    t = route(p, a);
    if (t < 0) return axil_pkg::RESP_DECERR;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) model[t][a[5:2]][8*b +: 8] = d[8*b +: 8];  // Byte merge
    end
    return axil_pkg::RESP_OKAY;
  endfunction

  // Expected {resp, data} of a read
  function automatic logic [33:0] ref_read(int p, axil_pkg::addr_t a);
    int t;
    t = route(p, a);
    if (t < 0) return {axil_pkg::RESP_DECERR, 32'h0};
    return {axil_pkg::RESP_OKAY, model[t][a[5:2]]};
  endfunction

  task automatic check(input string what, input logic [31:0] actual,
                       input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Sample at the falling edge, the beat moves on the next rising edge
  task automatic wait_beat(input int p, input int ch, output axil_pkg::axil_resp_t rsp);
    logic hit;
    hit = 1'b0;
    while (!hit) begin
      @(negedge clk_i);
      rsp = slv_resp[p];
      case (ch)
        0:       hit = rsp.aw_ready;
        1:       hit = rsp.w_ready;
        2:       hit = rsp.b_valid;
        3:       hit = rsp.ar_ready;
        default: hit = rsp.r_valid;
      endcase
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic axil_write(input int p, input axil_pkg::addr_t a, input axil_pkg::data_t d,
                            input axil_pkg::strb_t s, output axil_pkg::resp_t r);
    axil_pkg::axil_resp_t rsp;
    mgr_req[p].aw_addr  = a;
    mgr_req[p].aw_valid = 1'b1;
    wait_beat(p, 0, rsp);
    mgr_req[p].aw_valid = 1'b0;
    mgr_req[p].w_data   = d;  // W only after AW has gone
    mgr_req[p].w_strb   = s;
    mgr_req[p].w_valid  = 1'b1;
    wait_beat(p, 1, rsp);
    mgr_req[p].w_valid  = 1'b0;
    mgr_req[p].b_ready  = 1'b1;
    wait_beat(p, 2, rsp);
    mgr_req[p].b_ready  = 1'b0;
    r = rsp.b_resp;
  endtask

  task automatic axil_read(input int p, input axil_pkg::addr_t a,
                           output axil_pkg::data_t d, output axil_pkg::resp_t r);
    axil_pkg::axil_resp_t rsp;
    mgr_req[p].ar_addr  = a;
    mgr_req[p].ar_valid = 1'b1;
    wait_beat(p, 3, rsp);
    mgr_req[p].ar_valid = 1'b0;
    mgr_req[p].r_ready  = 1'b1;
    wait_beat(p, 4, rsp);
    mgr_req[p].r_ready  = 1'b0;
    d = rsp.r_data;
    r = rsp.r_resp;
  endtask

  task automatic write_check(input int p, input axil_pkg::addr_t a, input axil_pkg::data_t d,
                             input axil_pkg::strb_t s);
    axil_pkg::resp_t r;
    axil_pkg::resp_t exp_resp;
    exp_resp = ref_write(p, a, d, s);
    axil_write(p, a, d, s, r);
    check($sformatf("port %0d B resp at %h", p, a), 32'(r), 32'(exp_resp));
  endtask

  task automatic read_check(input int p, input axil_pkg::addr_t a);
    axil_pkg::data_t d;
    axil_pkg::resp_t r;
    logic [33:0]     exp_rd;
    exp_rd = ref_read(p, a);
    axil_read(p, a, d, r);
    check($sformatf("port %0d R resp at %h", p, a), 32'(r), 32'(exp_rd[33:32]));
    check($sformatf("port %0d R data at %h", p, a), d, exp_rd[31:0]);
  endtask

  // Each port owns its half of every memory, so the model stays order free
  task automatic run_random(input int p);
    logic [31:0]     r;
    int              region;
    int              start;
    axil_pkg::addr_t a;
    for (int n = 0; n < NUM_RAND; n++) begin
      r      = lcg_next();
      region = (r[31:29] == 3'd0) ? 2 : int'(r[28]);
      a      = make_addr(region, p * 8 + int'(r[26:24]));
      start  = cycles;
      if (r[22]) write_check(p, a, lcg_next(), r[19:16]);
      else read_check(p, a);
      // Round-robin bounds the wait behind the other port
      check($sformatf("port %0d took %0d cycles at %h", p, cycles - start, a),
            32'(cycles - start <= TXN_LAT), 32'd1);
    end
  endtask

  initial begin
    logic [31:0]     r;
    int              sp;
    axil_pkg::addr_t a;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    mgr_req[0]     = '0;
    mgr_req[1]     = '0;
    en_default     = 2'b00;
    default_idx    = 2'b11;  // Both slave ports default to master port 1
    addr_map[0]    = '{idx: 8'd0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
    addr_map[1]    = '{idx: 8'd1, start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
    lcg_state      = 32'd42;
    n_checks       = 0;
    n_errors       = 0;
    for (int k = 0; k < 16; k++) begin
      model[0][k] = FILL0 + 32'(k) * 32'h0101_0101;
      model[1][k] = FILL1 + 32'(k) * 32'h0101_0101;
    end

    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    #1;
    for (int p = 0; p < 2; p++) begin
      check($sformatf("slave port %0d handshakes after reset", p),
            32'({slv_resp[p].aw_ready, slv_resp[p].w_ready, slv_resp[p].b_valid,
                 slv_resp[p].ar_ready, slv_resp[p].r_valid}), 32'h0);
      check($sformatf("master port %0d handshakes after reset", p),
            32'({mst_req[p].aw_valid, mst_req[p].w_valid, mst_req[p].b_ready,
                 mst_req[p].ar_valid, mst_req[p].r_ready}), 32'h0);
    end
    @(posedge clk_i);
    #2;

    // Full-word write and read-back on every path
    for (int p = 0; p < 2; p++) begin
      for (int t = 0; t < 2; t++) begin
        write_check(p, make_addr(t, p * 2 + t), lcg_next(), 4'hF);
        read_check(p, make_addr(t, p * 2 + t));
      end
    end

    for (int n = 0; n < 16; n++) begin
      r  = lcg_next();
      sp = int'(r[31]);
      a  = make_addr(int'(r[30]), int'(r[27:24]));
      write_check(sp, a, lcg_next(), r[19:16]);  // Random strobes
      read_check(sp, a);
    end

    // Unmapped space, then the same with default routing on
    for (int p = 0; p < 2; p++) begin
      write_check(p, make_addr(2, 4 + p), lcg_next(), 4'hF);
      read_check(p, make_addr(2, 4 + p));
      read_check(p, make_addr(0, 4 + p));
      read_check(p, make_addr(1, 4 + p));
    end
    en_default = 2'b11;
    for (int p = 0; p < 2; p++) begin
      write_check(p, make_addr(2, 6 + p), lcg_next(), 4'hF);
      read_check(p, make_addr(2, 6 + p));
      read_check(p, make_addr(1, 6 + p));
    end
    en_default = 2'b00;

    fork
      run_random(0);
      run_random(1);
    join

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
source/axil_pkg.sv
source/xbar_pkg.sv
source/addr_decode.sv
source/axil_demux.sv
source/axil_mux.sv
source/axil_err_slv.sv
source/axil_xbar.sv
bench/tb_mem_slave.sv
bench/tb_axil_xbar.sv

//--- Makefile
# Verilator build and run of the AXI4-Lite crossbar testbench

VERILATOR ?= verilator
TOP       ?= tb_axil_xbar
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
